//--- verilog/exMem_cfg.svh
// Execute and memory configuration
`ifndef EXMEM_CFG_SVH
`define EXMEM_CFG_SVH

// Width of operands, ALU results and data memory words.
`define DATA_WIDTH 32

// Width of a destination register index, enough for 32 registers.
`define REG_ADDR_WIDTH 5

// Number of words in the data memory.
// The memory is word addressed, so byte address bits 1:0 are ignored.
`define DMEM_DEPTH 64

`endif

//--- verilog/cpuTypesPkg.sv
// Processor pipeline types
`default_nettype none

`include "exMem_cfg.svh"

package cpuTypesPkg;

  // Operation carried by a decoded instruction.
  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    AND = 4'h2,
    OR  = 4'h3,
    SLT = 4'h4,
    LUI = 4'h5,
    LW  = 4'h6,
    SW  = 4'h7,
    BEQ = 4'h8,
    NOP = 4'hF
  } opcodeT;

  // Function performed by the ALU in the execute stage.
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_LUI = 3'd5  // Shifts the immediate into the upper half.
  } aluOpT;

  // One decoded instruction with its operands already read.
  typedef struct packed {
    logic                       valid;
    opcodeT                     op;
    logic [`DATA_WIDTH-1:0]     pc;
    logic [`DATA_WIDTH-1:0]     rs1Val;
    logic [`DATA_WIDTH-1:0]     rs2Val;
    logic [`DATA_WIDTH-1:0]     imm;     // Sign extended by decode.
    logic [`REG_ADDR_WIDTH-1:0] destReg;
  } issueT;

  // Contents of the EX/MEM pipeline register.
  typedef struct packed {
    logic                       valid;
    opcodeT                     op;
    logic [`DATA_WIDTH-1:0]     aluResult;  // Also the address for LW and SW.
    logic [`DATA_WIDTH-1:0]     storeData;
    logic [`REG_ADDR_WIDTH-1:0] destReg;
  } exMemT;

  // One register file writeback.
  typedef struct packed {
    logic                       valid;
    logic [`REG_ADDR_WIDTH-1:0] destReg;
    logic [`DATA_WIDTH-1:0]     data;
  } wbT;

endpackage

`default_nettype wire

//--- verilog/executeStage.sv
// Execute stage ALU and branch
`timescale 1ns/1ps
`default_nettype none

`include "exMem_cfg.svh"

module executeStage
  import cpuTypesPkg::*;
(
  input  issueT                  issue,
  output exMemT                  exOut,
  output logic                   branchTaken,
  output logic [`DATA_WIDTH-1:0] branchTarget
);

  aluOpT                  aluOp;
  logic                   useImm;
  logic [`DATA_WIDTH-1:0] opA;
  logic [`DATA_WIDTH-1:0] opB;
  logic [`DATA_WIDTH-1:0] aluResult;
  logic                   aluZero;

  // Decode the opcode into an ALU function and an operand source.
  always_comb
  begin
    aluOp  = ALU_ADD;
    useImm = 1'b0;
    case (issue.op)
      ADD: aluOp = ALU_ADD;
      SUB: aluOp = ALU_SUB;
      AND: aluOp = ALU_AND;
      OR:  aluOp = ALU_OR;
      SLT: aluOp = ALU_SLT;
      LUI:
      begin
        aluOp  = ALU_LUI;
        useImm = 1'b1;
      end
      LW, SW:
      begin
        aluOp  = ALU_ADD;  // Base register plus offset.
        useImm = 1'b1;
      end
      BEQ: aluOp = ALU_SUB;  // Equal operands give a zero difference.
      default: aluOp = ALU_ADD;
    endcase
  end

  assign opA = issue.rs1Val;
  assign opB = useImm ? issue.imm : issue.rs2Val;

  always_comb
  begin
    case (aluOp)
      ALU_ADD: aluResult = opA + opB;
      ALU_SUB: aluResult = opA - opB;
      ALU_AND: aluResult = opA & opB;
      ALU_OR:  aluResult = opA | opB;
      ALU_SLT: aluResult = {{(`DATA_WIDTH-1){1'b0}}, ($signed(opA) < $signed(opB))};
      ALU_LUI: aluResult = {opB[`DATA_WIDTH/2-1:0], {(`DATA_WIDTH/2){1'b0}}};
      default: aluResult = '0;
    endcase
  end

  assign aluZero = (aluResult == '0);

  // Branch resolution happens in the issue cycle.
  assign branchTaken  = issue.valid && (issue.op == BEQ) && aluZero;
  assign branchTarget = issue.pc + `DATA_WIDTH'(4) + (issue.imm << 2);

  always_comb
  begin
    exOut.valid     = issue.valid;
    exOut.op        = issue.op;
    exOut.aluResult = aluResult;
    exOut.storeData = issue.rs2Val;  // Only SW makes use of it.
    exOut.destReg   = issue.destReg;
  end

endmodule

`default_nettype wire

//--- verilog/pipeRegExMem.sv
// EX/MEM pipeline register
`timescale 1ns/1ps
`default_nettype none

module pipeRegExMem
  import cpuTypesPkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  enable,
  input  logic  flush,
  input  exMemT exOut,
  output exMemT memIn
);

  exMemT held;   // Payload as last loaded.
  logic  fresh;  // Set on the cycle after an enabled load.

  // Flush takes priority over enable and clears the whole register.
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      held  <= '0;
      fresh <= 1'b0;
    end
    else if (flush)
    begin
      held  <= '0;
      fresh <= 1'b0;
    end
    else if (enable)
    begin
      held  <= exOut;
      fresh <= 1'b1;
    end
    else
    begin
      fresh <= 1'b0;  // Stalled, so the payload is held but shown only once.
    end
  end

  // The payload stays visible while stalled, but valid lasts one cycle.
  always_comb
  begin
    memIn       = held;
    memIn.valid = held.valid & fresh;
  end

endmodule

`default_nettype wire

//--- verilog/memoryStage.sv
// Memory stage and writeback register
`timescale 1ns/1ps
`default_nettype none

`include "exMem_cfg.svh"

module memoryStage
  import cpuTypesPkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  exMemT memIn,
  output wbT    wb
);

  localparam int AddrBits = $clog2(`DMEM_DEPTH);

  logic [`DATA_WIDTH-1:0] dmem [`DMEM_DEPTH];
  logic [AddrBits-1:0]    wordAddr;
  logic [`DATA_WIDTH-1:0] loadWord;
  logic                   storeEn;
  logic                   writesBack;
  wbT                     wbNext;

  // Byte address to word index.
  assign wordAddr = memIn.aluResult[AddrBits+1:2];
  assign storeEn  = memIn.valid && (memIn.op == SW);

  always_ff @(posedge CLK)
  begin
    if (storeEn)
    begin
      dmem[wordAddr] <= memIn.storeData;
    end
  end

  assign loadWord = dmem[wordAddr];  // Asynchronous read.

  // Only ALU operations and loads return a value to the register file.
  always_comb
  begin
    case (memIn.op)
      ADD, SUB, AND, OR, SLT, LUI, LW: writesBack = 1'b1;
      default:                         writesBack = 1'b0;
    endcase
  end

  always_comb
  begin
    wbNext.valid   = memIn.valid && writesBack;
    wbNext.destReg = memIn.destReg;
    wbNext.data    = (memIn.op == LW) ? loadWord : memIn.aluResult;
  end

  // The writeback payload only moves when there is something to write.
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      wb <= '0;
    end
    else
    begin
      wb.valid <= wbNext.valid;
      if (wbNext.valid)
      begin
        wb.destReg <= wbNext.destReg;
        wb.data    <= wbNext.data;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/exMemTop.sv
// Execute to memory pipeline section
`timescale 1ns/1ps
`default_nettype none

`include "exMem_cfg.svh"

module exMemTop
  import cpuTypesPkg::*;
(
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   enable,
  input  logic                   flush,
  input  issueT                  issue,
  output wbT                     wb,
  output logic                   branchTaken,
  output logic [`DATA_WIDTH-1:0] branchTarget
);

  exMemT exOut;  // Execute result before the pipeline register.
  exMemT memIn;  // Register output feeding the memory stage.

  executeStage execute (
    .issue        (issue),
    .exOut        (exOut),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  pipeRegExMem exMemReg (
    .CLK    (CLK),
    .nRST   (nRST),
    .enable (enable),
    .flush  (flush),
    .exOut  (exOut),
    .memIn  (memIn)
  );

  memoryStage memory (
    .CLK   (CLK),
    .nRST  (nRST),
    .memIn (memIn),
    .wb    (wb)
  );

endmodule

`default_nettype wire

//--- verif/exMemTop_assertions.sv
// Pipeline protocol assertions
`timescale 1ns/1ps
`default_nettype none

module exMemTop_assertions
  import cpuTypesPkg::*;
(
  input logic  CLK,
  input logic  nRST,
  input logic  flush,
  input issueT issue,
  input wbT    wb
);

  int failCount = 0;  // Read by the testbench for its closing report.

  wbValidKnown: assert property (@(posedge CLK) disable iff (!nRST) !$isunknown(wb.valid))
  else
  begin
    $error("wb.valid is unknown after reset");
    failCount++;
  end

  // A flushed register has nothing to hand to the writeback register.
  flushBlocksWb: assert property (@(posedge CLK) disable iff (!nRST) flush |=> ##1 !wb.valid)
  else
  begin
    $error("Writeback strobe one edge after a flush");
    failCount++;
  end

  noWbForStoreOrBranch: assert property (@(posedge CLK) disable iff (!nRST)
    (issue.valid && (issue.op == SW || issue.op == BEQ)) |-> ##2 !wb.valid)
  else
  begin
    $error("Writeback strobe two cycles after a store or branch");
    failCount++;
  end

endmodule

bind exMemTop exMemTop_assertions exMemChecks (
  .CLK   (CLK),
  .nRST  (nRST),
  .flush (flush),
  .issue (issue),
  .wb    (wb)
);

`default_nettype wire

//--- verif/exMemTb.sv
// Execute to memory testbench
`timescale 1ns/1ps
`default_nettype none

`include "exMem_cfg.svh"

module exMemTb
  import cpuTypesPkg::*;
();

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 16;
  localparam int AluCount    = 12;
  localparam int MemCount    = 8;
  // Fixed length tests plus the drains, doubled as a margin.
  localparam int RunCycles   = 2 * (ResetCycles + AluCount + 2 * MemCount + 60);

  logic                   CLK;
  logic                   nRST;
  logic                   enable;
  logic                   flush;
  issueT                  issue;
  wbT                     wb;
  logic                   branchTaken;
  logic [`DATA_WIDTH-1:0] branchTarget;

  wbT                     expQ [$];  // Predicted writebacks in issue order.
  int                     dueQ [$];  // Cycle on which each predicted writeback is due.
  int                     cycleCount = 0;
  logic [`DATA_WIDTH-1:0] memModel [`DMEM_DEPTH];
  logic [`DATA_WIDTH-1:0] pcNext;
  int                     valueErrors    = 0;
  int                     protocolErrors = 0;

  exMemTop DUT (.*);

  initial
  begin
    CLK = 1'b0;
    forever #(ClkPeriod / 2) CLK = ~CLK;
  end

  // Rising edges seen so far, used to check the writeback latency.
  always @(posedge CLK)
    cycleCount++;

  initial
  begin
    #(RunCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles before the tests finished.", RunCycles);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic writesBack(opcodeT op);
    return op inside {ADD, SUB, AND, OR, SLT, LUI, LW};
  endfunction

  // Result that the register file should receive for an accepted item.
  function automatic logic [`DATA_WIDTH-1:0] predictData(issueT item);
    logic [`DATA_WIDTH-1:0] addr;
    addr = item.rs1Val + item.imm;
    case (item.op)
      ADD: return item.rs1Val + item.rs2Val;
      SUB: return item.rs1Val - item.rs2Val;
      AND: return item.rs1Val & item.rs2Val;
      OR:  return item.rs1Val | item.rs2Val;
      SLT: return ($signed(item.rs1Val) < $signed(item.rs2Val)) ? 1 : 0;
      LUI: return {item.imm[15:0], 16'h0000};
      LW:  return memModel[(addr >> 2) % `DMEM_DEPTH];
      default: return '0;
    endcase
  endfunction

  task automatic reportValue(string name, logic [`DATA_WIDTH-1:0] expected,
                             logic [`DATA_WIDTH-1:0] actual);
    valueErrors++;
    $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  // Holds one instruction on issue for a single cycle.
  task automatic issueOp(opcodeT op, logic [`DATA_WIDTH-1:0] a, logic [`DATA_WIDTH-1:0] b,
                         logic [`DATA_WIDTH-1:0] imm, logic [`REG_ADDR_WIDTH-1:0] rd,
                         logic en = 1'b1, logic fl = 1'b0);
    issueT item;
    item = '{valid: 1'b1, op: op, pc: pcNext, rs1Val: a, rs2Val: b, imm: imm, destReg: rd};
    @(negedge CLK);
    issue  = item;
    enable = en;
    flush  = fl;
    pcNext = pcNext + 4;
    if (en && !fl)
    begin
      if (writesBack(op))
      begin
        expQ.push_back('{valid: 1'b1, destReg: rd, data: predictData(item)});
        dueQ.push_back(cycleCount + 2);  // Captured at the next edge, written back at the one after.
      end
      if (op == SW)
        memModel[((a + imm) >> 2) % `DMEM_DEPTH] = b;  // Store lands before any later load.
    end
  endtask

  task automatic idle(int cycles);
    repeat (cycles)
    begin
      @(negedge CLK);
      issue    = '0;
      issue.op = NOP;
      enable   = 1'b1;
      flush    = 1'b0;
    end
  endtask

  task automatic drainWb();
    int waited;
    idle(1);
    waited = 0;
    while (expQ.size() > 0 && waited < 8)
    begin
      @(posedge CLK);
      waited++;
    end
    assert (expQ.size() == 0)
    else
    begin
      protocolErrors++;
      $display("Error at %0t: %0d predicted writebacks never arrived", $time, expQ.size());
    end
    expQ.delete();
    dueQ.delete();
    idle(3);  // Room for a stray writeback to show up.
  endtask

  // Every writeback strobe must match the oldest prediction.
  always @(negedge CLK)
  begin : wbMonitor
    wbT expected;
    int due;
    if (nRST && wb.valid)
    begin
      assert (expQ.size() > 0)
      else
      begin
        protocolErrors++;
        $display("Error at %0t: writeback to r%0d that no accepted item explains",
                 $time, wb.destReg);
      end
      if (expQ.size() > 0)
      begin
        expected = expQ.pop_front();
        due      = dueQ.pop_front();
        assert (cycleCount == due)
        else
        begin
          protocolErrors++;
          $display("Error at %0t: writeback to r%0d came at cycle %0d instead of cycle %0d",
                   $time, wb.destReg, cycleCount, due);
        end
        assert (wb.destReg == expected.destReg)
        else reportValue("wb.destReg", expected.destReg, wb.destReg);
        assert (wb.data == expected.data)
        else reportValue("wb.data", expected.data, wb.data);
      end
    end
  end

  task automatic checkReset();
    for (int i = 0; i < ResetCycles + 2; i++)
    begin
      @(negedge CLK);
      if (i == ResetCycles)
        nRST = 1'b1;
      assert (!wb.valid && !branchTaken)
      else
      begin
        protocolErrors++;
        $display("Error at %0t: wb.valid or branchTaken high around reset", $time);
      end
    end
  endtask

  task automatic testAlu();
    opcodeT aluOps [6] = '{ADD, SUB, AND, OR, SLT, LUI};
    repeat (AluCount)
      issueOp(aluOps[$urandom_range(0, 5)], $urandom, $urandom, $urandom, $urandom_range(1, 31));
    drainWb();
  endtask

  task automatic testMemory();
    logic [`DATA_WIDTH-1:0] base [MemCount];
    logic [`DATA_WIDTH-1:0] offset [MemCount];
    for (int i = 0; i < MemCount; i++)
    begin
      base[i]   = $urandom;
      offset[i] = $urandom_range(0, 255);
      issueOp(SW, base[i], $urandom, offset[i], '0);
    end
    for (int i = 0; i < MemCount; i++)
      issueOp(LW, base[i], '0, offset[i], i + 1);
    drainWb();
  endtask

  task automatic testStall();
    issueOp(ADD, $urandom, $urandom, '0, 3);
    repeat (4)
      issueOp(SUB, $urandom, $urandom, '0, 4, 1'b0);  // Dropped while stalled.
    drainWb();
  endtask

  task automatic testFlush();
    logic [`DATA_WIDTH-1:0] base;
    base = $urandom;
    issueOp(SW, base, $urandom, 32'h10, '0);
    issueOp(OR, $urandom, $urandom, '0, 7);  // Already in the register when the flush hits.
    issueOp(SW, base, $urandom, 32'h10, '0, 1'b1, 1'b1);
    issueOp(ADD, $urandom, $urandom, '0, 8, 1'b1, 1'b1);
    idle(1);
    // The load must still see the first store.
    issueOp(LW, base, '0, 32'h10, 9);
    drainWb();
  endtask

  task automatic testBranch();
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] imm;
    logic [`DATA_WIDTH-1:0] target;
    for (int i = 0; i < 3; i++)
    begin
      a      = $urandom;
      imm    = $urandom_range(0, 511) - 256;
      target = pcNext + 4 + (imm << 2);
      // The last item is a SUB of equal operands, a zero result that must not branch.
      issueOp((i == 2) ? SUB : BEQ, a, (i == 1) ? (a ^ 32'h1) : a, imm, 10);
      #(ClkPeriod / 10);
      assert (branchTaken == (i == 0))
      else reportValue("branchTaken", i == 0, branchTaken);
      assert (i == 2 || branchTarget == target)
      else reportValue("branchTarget", target, branchTarget);
    end
    drainWb();
  endtask

  initial
  begin
    void'($urandom(73));
    nRST     = 1'b0;
    enable   = 1'b1;
    flush    = 1'b0;
    issue    = '0;
    issue.op = NOP;
    pcNext   = 32'h0000_1000;
    checkReset();
    testAlu();
    testMemory();
    testStall();
    testFlush();
    testBranch();
    $display("Errors: %0d wrong values, %0d protocol, %0d assertion failures",
             valueErrors, protocolErrors, DUT.exMemChecks.failCount);
    if (valueErrors + protocolErrors + DUT.exMemChecks.failCount == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/cpuTypesPkg.sv
verilog/executeStage.sv
verilog/pipeRegExMem.sv
verilog/memoryStage.sv
verilog/exMemTop.sv
verif/exMemTop_assertions.sv
verif/exMemTb.sv

//--- Bender.yml
package:
  name: ex_mem_pipeline

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpuTypesPkg.sv
      - verilog/executeStage.sv
      - verilog/pipeRegExMem.sv
      - verilog/memoryStage.sv
      - verilog/exMemTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/exMemTop_assertions.sv
      - verif/exMemTb.sv
